/* vlog.f */
verilog/fetch_pkg.sv
verilog/thread_pc.sv
verilog/thread_select.sv
verilog/if_stage.sv
bench/if_stage_properties.sv
bench/if_stage_tb.sv

/* bench/if_stage_tb.sv */
module if_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLE_LIMIT = 600;  // ~460 cycles of stimulus plus margin

	logic                 clock = 1'b0;
	logic                 reset;
	logic                 is_two_threads;
	logic                 thread1_branch_taken;
	logic                 thread2_branch_taken;
	fetch_pkg::addr_t     thread1_target_pc;
	fetch_pkg::addr_t     thread2_target_pc;
	fetch_pkg::stall_t    thread1_stall;
	fetch_pkg::stall_t    thread2_stall;
	fetch_pkg::mem_word_t imem_data;
	logic                 imem_valid;
	fetch_pkg::addr_t     proc2imem_addr;
	fetch_pkg::addr_t     next_pc_out;
	fetch_pkg::inst_t     inst1_out;
	fetch_pkg::inst_t     inst2_out;
	logic                 inst1_valid;
	logic                 inst2_valid;
	logic                 thread1_is_available;

	int unsigned cycle_count = 0;
	logic [31:0] rng_state   = 32'h5e5eefc3;  // xorshift seed

	if_stage dut (.*);

	always #4 clock = ~clock;  // 8 ns period

	// combinational memory, every instruction word equals its own address
	assign imem_data = {proc2imem_addr[31:0] + 32'd4, proc2imem_addr[31:0]};

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic run_cycles(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial
	begin
		reset                = 1'b1;
		is_two_threads       = 1'b1;    // selector state itself must come out of reset on thread 1
		thread1_branch_taken = 1'b0;
		thread2_branch_taken = 1'b0;
		thread1_target_pc    = '0;
		thread2_target_pc    = '0;
		thread1_stall        = '0;
		thread2_stall        = '0;
		imem_valid           = 1'b1;    // only reset keeps the valids low here
		run_cycles(8);
		reset          = 1'b0;
		is_two_threads = 1'b0;
		run_cycles(10);                 // straight line on thread 1

		thread1_branch_taken = 1'b1;    // jump into the upper slot
		thread1_target_pc    = 64'h204;
		run_cycles(1);
		thread1_branch_taken = 1'b0;
		run_cycles(4);

		// each stall source on its own, then a memory miss
		for (int i = 0; i < 4; i++)
		begin
			thread1_stall = fetch_pkg::stall_t'(4'b0001 << i);
			run_cycles(2);
		end
		thread1_stall = '0;
		imem_valid    = 1'b0;
		run_cycles(2);
		imem_valid = 1'b1;
		run_cycles(2);

		is_two_threads = 1'b1;          // round robin
		run_cycles(12);

		// redirects while stalled, stride 3 so both owners are hit
		for (int i = 0; i < 2; i++)
		begin
			thread1_branch_taken = 1'b1;
			thread1_target_pc    = 64'h404 + 64'(i * 8);
			thread2_branch_taken = 1'b1;
			thread2_target_pc    = 64'h3008 + 64'(i * 4);
			thread2_stall.rs     = 1'b1;
			run_cycles(1);
			thread1_branch_taken = 1'b0;
			thread2_branch_taken = 1'b0;
			thread2_stall        = '0;
			run_cycles(2);
		end

		// random mix of modes, stalls, misses and redirects
		repeat (400)
		begin
			rng_state            = xorshift(rng_state);
			is_two_threads       = rng_state[1:0] != 2'b00;
			imem_valid           = rng_state[4:2] != 3'b000;
			thread1_stall        = (rng_state[7:5] == 3'b000) ?
				fetch_pkg::stall_t'(rng_state[11:8]) : '0;
			thread1_branch_taken = rng_state[15:12] == 4'h0;
			thread1_target_pc    = {52'h0, rng_state[27:18], 2'b00};
			rng_state            = xorshift(rng_state);
			thread2_stall        = (rng_state[7:5] == 3'b000) ?
				fetch_pkg::stall_t'(rng_state[11:8]) : '0;
			thread2_branch_taken = rng_state[15:12] == 4'h0;
			thread2_target_pc    = {48'h0, 4'h1, rng_state[27:18], 2'b00};  // 0x1000 region
			run_cycles(1);
		end

		thread1_branch_taken = 1'b0;
		thread2_branch_taken = 1'b0;
		thread1_stall        = '0;
		thread2_stall        = '0;
		run_cycles(4);                  // let the last checks sample

		$display("summary %0d cycles, %0d assertion failures",
			cycle_count, dut.props.error_count);
		if (dut.props.error_count == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	//////////////////////////////////////////////////
	// timeout
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout, stimulus did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

/* bench/if_stage_properties.sv */
module if_stage_properties (
	input logic              clock,
	input logic              reset,
	input logic              is_two_threads,
	input logic              thread1_branch_taken,
	input logic              thread2_branch_taken,
	input fetch_pkg::addr_t  thread1_target_pc,
	input fetch_pkg::addr_t  thread2_target_pc,
	input fetch_pkg::stall_t thread1_stall,
	input fetch_pkg::stall_t thread2_stall,
	input logic              imem_valid,
	input fetch_pkg::addr_t  proc2imem_addr,
	input fetch_pkg::addr_t  next_pc_out,
	input fetch_pkg::inst_t  inst1_out,
	input fetch_pkg::inst_t  inst2_out,
	input logic              inst1_valid,
	input logic              inst2_valid,
	input logic              thread1_is_available
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned error_count = 0;  // failed checks so far

	fetch_pkg::thread_state_e exp_state;  // expected round robin position
	fetch_pkg::addr_t exp_pc1;            // expected thread 1 pc
	fetch_pkg::addr_t exp_pc2;            // expected thread 2 pc
	fetch_pkg::addr_t own_pc;             // pc of the thread that owns fetch
	fetch_pkg::addr_t own_step;           // 4 from the upper slot, else 8
	fetch_pkg::addr_t exp_addr;
	fetch_pkg::addr_t exp_next_pc;
	fetch_pkg::inst_t exp_inst1;
	fetch_pkg::inst_t exp_inst2;
	logic exp_owner1;                     // thread 1 owns fetch this cycle
	logic own_odd;                        // owner pc sits on the upper slot
	logic exp_ok;                         // owner fetch should succeed
	logic reset_q;                        // reset seen at the previous edge

	//////////////////////////////////////////////////
	// reference model of the fetch rules
	//////////////////////////////////////////////////

	always_comb
	begin
		exp_owner1 = !is_two_threads || (exp_state == fetch_pkg::THREAD1_IS_EX);
		own_pc     = exp_owner1 ? exp_pc1 : exp_pc2;
		own_odd    = own_pc[2];
		own_step   = own_odd ? 64'd4 : 64'd8;
		exp_addr   = {own_pc[63:3], 3'b000};           // word aligned
		exp_next_pc = own_pc + own_step;
		// memory word holds its own addresses, so each slot equals its pc
		exp_inst1  = own_pc[31:0];
		exp_inst2  = own_pc[31:0] + 32'd4;
		if (exp_owner1)
		begin
			exp_ok = imem_valid & ~(|thread1_stall) & ~thread1_branch_taken;
		end
		else
		begin
			exp_ok = imem_valid & ~(|thread2_stall) & ~thread2_branch_taken;
		end
	end

	always_ff @(posedge clock)
	begin
		reset_q <= reset;
		if (reset)
		begin
			exp_state <= fetch_pkg::THREAD1_IS_EX;
			exp_pc1   <= fetch_pkg::THREAD1_RESET_PC;
			exp_pc2   <= fetch_pkg::THREAD2_RESET_PC;
		end
		else
		begin
			if (!is_two_threads || exp_state == fetch_pkg::THREAD2_IS_EX)
			begin
				exp_state <= fetch_pkg::THREAD1_IS_EX;
			end
			else
			begin
				exp_state <= fetch_pkg::THREAD2_IS_EX;
			end
			// a redirect loads even when stalled or not selected
			if (thread1_branch_taken)
			begin
				exp_pc1 <= thread1_target_pc;
			end
			else if (exp_owner1 && exp_ok)
			begin
				exp_pc1 <= exp_next_pc;
			end
			if (thread2_branch_taken)
			begin
				exp_pc2 <= thread2_target_pc;
			end
			else if (!exp_owner1 && exp_ok)
			begin
				exp_pc2 <= exp_next_pc;
			end
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	reset_state: assert property (@(posedge clock)
		reset && reset_q |-> !inst1_valid && !inst2_valid && thread1_is_available
			&& proc2imem_addr == fetch_pkg::THREAD1_RESET_PC)
	else
	begin
		error_count++;
		$error("fetch outputs are not in their reset state while reset is held");
	end

	owner_rule: assert property (@(posedge clock) disable iff (reset)
		thread1_is_available == exp_owner1)
	else
	begin
		error_count++;
		$error("ERR thread1_is_available got %h expected %h",
			$sampled(thread1_is_available), $sampled(exp_owner1));
	end

	addr_rule: assert property (@(posedge clock) disable iff (reset)
		proc2imem_addr == exp_addr)
	else
	begin
		error_count++;
		$error("ERR proc2imem_addr got %h expected %h",
			$sampled(proc2imem_addr), $sampled(exp_addr));
	end

	valid_rule: assert property (@(posedge clock) disable iff (reset)
		{inst1_valid, inst2_valid} == {exp_ok, exp_ok & ~own_odd})
	else
	begin
		error_count++;
		$error("ERR inst1_valid/inst2_valid got %h expected %h",
			$sampled({inst1_valid, inst2_valid}), $sampled({exp_ok, exp_ok & ~own_odd}));
	end

	slot_rule: assert property (@(posedge clock) disable iff (reset)
		exp_ok |-> inst1_out == exp_inst1 && (own_odd || inst2_out == exp_inst2))
	else
	begin
		error_count++;
		$error("ERR inst1_out/inst2_out got %h %h expected %h %h",
			$sampled(inst1_out), $sampled(inst2_out), $sampled(exp_inst1), $sampled(exp_inst2));
	end

	next_pc_rule: assert property (@(posedge clock) disable iff (reset)
		exp_ok |-> next_pc_out == exp_next_pc)
	else
	begin
		error_count++;
		$error("ERR next_pc_out got %h expected %h",
			$sampled(next_pc_out), $sampled(exp_next_pc));
	end

endmodule

bind if_stage if_stage_properties props (.*);

/* verilog/if_stage.sv */
module if_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 is_two_threads,        // round robin on when high

	// redirects from execute, one per thread
	input  logic                 thread1_branch_taken,
	input  logic                 thread2_branch_taken,
	input  fetch_pkg::addr_t     thread1_target_pc,
	input  fetch_pkg::addr_t     thread2_target_pc,

	// back-pressure bundles
	input  fetch_pkg::stall_t    thread1_stall,
	input  fetch_pkg::stall_t    thread2_stall,

	// instruction memory, answers in the same cycle
	input  fetch_pkg::mem_word_t imem_data,
	input  logic                 imem_valid,
	output fetch_pkg::addr_t     proc2imem_addr,

	// towards decode
	output fetch_pkg::addr_t     next_pc_out,
	output fetch_pkg::inst_t     inst1_out,
	output fetch_pkg::inst_t     inst2_out,
	output logic                 inst1_valid,
	output logic                 inst2_valid,
	output logic                 thread1_is_available   // which thread the slots belong to
);

	//////////////////////////////////////////////////
	// wiring between the PC units and the selector
	//////////////////////////////////////////////////

	logic              fetch_enable1;  // selector grants thread 1
	logic              fetch_enable2;  // selector grants thread 2
	fetch_pkg::fetch_t fetch1;         // thread 1 address, next pc, slots
	fetch_pkg::fetch_t fetch2;         // thread 2 address, next pc, slots

	//////////////////////////////////////////////////
	// thread 1 PC
	//////////////////////////////////////////////////

	thread_pc #(
		.reset_pc     (fetch_pkg::THREAD1_RESET_PC)
	) pc1 (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable1),
		.branch_taken (thread1_branch_taken),
		.target_pc    (thread1_target_pc),
		.stall        (thread1_stall),
		.imem_data    (imem_data),          // same word goes to both units
		.imem_valid   (imem_valid),
		.fetch        (fetch1)
	);

	//////////////////////////////////////////////////
	// thread 2 PC
	//////////////////////////////////////////////////

	thread_pc #(
		.reset_pc     (fetch_pkg::THREAD2_RESET_PC)
	) pc2 (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable2),
		.branch_taken (thread2_branch_taken),
		.target_pc    (thread2_target_pc),
		.stall        (thread2_stall),
		.imem_data    (imem_data),
		.imem_valid   (imem_valid),
		.fetch        (fetch2)
	);

	//////////////////////////////////////////////////
	// thread selector
	//////////////////////////////////////////////////

	// picks one unit per cycle and drives all top outputs
	thread_select select (
		.clock                (clock),
		.reset                (reset),
		.is_two_threads       (is_two_threads),
		.fetch1               (fetch1),
		.fetch2               (fetch2),
		.fetch_enable1        (fetch_enable1),
		.fetch_enable2        (fetch_enable2),
		.proc2imem_addr       (proc2imem_addr),
		.next_pc_out          (next_pc_out),
		.inst1_out            (inst1_out),
		.inst2_out            (inst2_out),
		.inst1_valid          (inst1_valid),
		.inst2_valid          (inst2_valid),
		.thread1_is_available (thread1_is_available)
	);

endmodule

/* verilog/thread_select.sv */
module thread_select (
	input  logic              clock,
	input  logic              reset,
	input  logic              is_two_threads,        // low keeps fetch on thread 1
	input  fetch_pkg::fetch_t fetch1,                // offer from thread 1
	input  fetch_pkg::fetch_t fetch2,                // offer from thread 2
	output logic              fetch_enable1,         // thread 1 may fetch
	output logic              fetch_enable2,         // thread 2 may fetch
	output fetch_pkg::addr_t  proc2imem_addr,        // shared memory address
	output fetch_pkg::addr_t  next_pc_out,           // owner's sequential pc
	output fetch_pkg::inst_t  inst1_out,             // decode slot 1
	output fetch_pkg::inst_t  inst2_out,             // decode slot 2
	output logic              inst1_valid,
	output logic              inst2_valid,
	output logic              thread1_is_available   // thread 1 owns fetch
);

	fetch_pkg::thread_state_e state;        // round robin position
	fetch_pkg::thread_state_e next_state;
	fetch_pkg::thread_state_e owner;        // who really fetches this cycle
	fetch_pkg::fetch_t        owner_fetch;  // the selected unit's offer

	//////////////////////////////////////////////////
	// round robin FSM
	//////////////////////////////////////////////////

	// toggles every edge in two thread mode, parks on thread 1 otherwise
	always_comb
	begin
		if (!is_two_threads)
		begin
			next_state = fetch_pkg::THREAD1_IS_EX;
		end
		else
		begin
			case (state)
				fetch_pkg::THREAD1_IS_EX:
				begin
					next_state = fetch_pkg::THREAD2_IS_EX;
				end
				default:
				begin
					next_state = fetch_pkg::THREAD1_IS_EX;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= fetch_pkg::THREAD1_IS_EX;  // thread 1 starts
		end
		else
		begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////
	// owner of the fetch port
	//////////////////////////////////////////////////

	// single thread mode overrides a stale state in the same cycle
	always_comb
	begin
		if (is_two_threads)
		begin
			owner = state;
		end
		else
		begin
			owner = fetch_pkg::THREAD1_IS_EX;
		end
	end

	assign fetch_enable1        = (owner == fetch_pkg::THREAD1_IS_EX);
	assign fetch_enable2        = (owner == fetch_pkg::THREAD2_IS_EX);
	assign thread1_is_available = fetch_enable1;

	//////////////////////////////////////////////////
	// output mux
	//////////////////////////////////////////////////

	always_comb
	begin
		case (owner)
			fetch_pkg::THREAD2_IS_EX:
			begin
				owner_fetch = fetch2;
			end
			default:
			begin
				owner_fetch = fetch1;
			end
		endcase
	end

	// everything below follows the same owner, next pc included
	assign proc2imem_addr = owner_fetch.addr;
	assign next_pc_out    = owner_fetch.next_pc;
	assign inst1_out      = owner_fetch.inst1;
	assign inst2_out      = owner_fetch.inst2;
	assign inst1_valid    = owner_fetch.inst1_valid;  // low on stall or miss
	assign inst2_valid    = owner_fetch.inst2_valid;  // also low for upper slot pc

endmodule

/* verilog/thread_pc.sv */
module thread_pc #(
	parameter fetch_pkg::addr_t reset_pc = fetch_pkg::THREAD1_RESET_PC  // PC after reset
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_enable,  // this thread owns fetch this cycle
	input  logic                  branch_taken,  // redirect from execute
	input  fetch_pkg::addr_t      target_pc,     // redirect destination
	input  fetch_pkg::stall_t     stall,         // back-pressure for this thread
	input  fetch_pkg::mem_word_t  imem_data,     // shared memory word
	input  logic                  imem_valid,    // memory answered this cycle
	output fetch_pkg::fetch_t     fetch          // address, next pc and slots
);

	//////////////////////////////////////////////////
	// internal signals
	//////////////////////////////////////////////////

	fetch_pkg::addr_t pc;          // program counter of this thread
	fetch_pkg::addr_t fetch_addr;  // pc rounded down to the memory word
	fetch_pkg::addr_t seq_pc;      // where we go after a good fetch
	fetch_pkg::inst_t low_inst;    // lower addressed slot of the word
	fetch_pkg::inst_t high_inst;   // upper addressed slot of the word
	logic             odd_slot;    // pc points at the upper slot
	logic             stalled;     // any back-pressure source active
	logic             fetch_ok;    // instructions leave this cycle

	//////////////////////////////////////////////////
	// address and slot split
	//////////////////////////////////////////////////

	// bit 2 picks the slot inside the 8 byte word
	assign odd_slot = pc[2];

	// memory is addressed in whole 64 bit words
	assign fetch_addr = {pc[63:3], 3'b000};

	// little end first: lower address sits in the low half
	assign low_inst  = imem_data[31:0];
	assign high_inst = imem_data[63:32];

	// from the upper slot only one instruction leaves, so step 4
	// from the lower slot both leave, so step 8
	always_comb
	begin
		if (odd_slot)
		begin
			seq_pc = pc + fetch_pkg::INST_STEP;   // lands on the next aligned word
		end
		else
		begin
			seq_pc = pc + fetch_pkg::FETCH_STEP;  // skip the whole word
		end
	end

	//////////////////////////////////////////////////
	// fetch success
	//////////////////////////////////////////////////

	// any one of these freezes the thread
	assign stalled = stall.rs
		| stall.rob
		| stall.rat
		| stall.mem_hazard;

	// a redirect kills whatever comes back this cycle, and nothing
	// leaves while the unit is held in reset
	assign fetch_ok = fetch_enable
		& imem_valid
		& ~stalled
		& ~branch_taken
		& ~reset;

	//////////////////////////////////////////////////
	// result towards the selector
	//////////////////////////////////////////////////

	always_comb
	begin
		fetch.addr    = fetch_addr;
		fetch.next_pc = seq_pc;

		if (odd_slot)
		begin
			fetch.inst1 = high_inst;  // only the upper slot is ours
			fetch.inst2 = '0;         // nothing useful in slot 2
		end
		else
		begin
			fetch.inst1 = low_inst;
			fetch.inst2 = high_inst;
		end

		// slot 2 only exists for an aligned pc
		fetch.inst1_valid = fetch_ok;
		fetch.inst2_valid = fetch_ok & ~odd_slot;
	end

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////

	// redirect wins over everything, even when this thread is not
	// selected or is stalled; otherwise advance only on a good fetch
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= reset_pc;
		end
		else if (branch_taken)
		begin
			pc <= target_pc;  // may land on either slot
		end
		else if (fetch_ok)
		begin
			pc <= seq_pc;
		end
		// else hold for stall, memory miss or other thread's turn
	end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [63:0] addr_t;      // byte address into instruction memory
	typedef logic [31:0] inst_t;      // one instruction word
	typedef logic [63:0] mem_word_t;  // one memory beat, two instruction slots

	// byte steps between slots and between aligned fetch words
	localparam addr_t INST_STEP  = 64'd4;
	localparam addr_t FETCH_STEP = 64'd8;

	//////////////////////////////////////////////////
	// thread ownership of the fetch port
	//////////////////////////////////////////////////

	typedef enum logic
	{
		THREAD1_IS_EX = 1'b0,  // thread 1 drives the address this cycle
		THREAD2_IS_EX = 1'b1   // thread 2 drives the address this cycle
	} thread_state_e;

	// everything that can freeze one thread's PC
	typedef struct packed
	{
		logic rs;          // reservation stations full, shared
		logic rob;         // this thread's reorder buffer full
		logic rat;         // free list empty, shared
		logic mem_hazard;  // data side owns memory this cycle
	} stall_t;

	// what one PC unit offers to the thread selector
	typedef struct packed
	{
		addr_t addr;         // aligned fetch address
		addr_t next_pc;      // sequential PC after this fetch
		inst_t inst1;        // first slot
		inst_t inst2;        // second slot
		logic  inst1_valid;
		logic  inst2_valid;
	} fetch_t;

	// per-thread start addresses
	localparam addr_t THREAD1_RESET_PC = 64'h0;
	localparam addr_t THREAD2_RESET_PC = 64'h1000;

endpackage
